// File: run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module sonic_vc_bridge_tb \
   --Mdir obj_dir -o sim_bridge
./obj_dir/sim_bridge > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
   exit 1
fi
grep -q "TEST RESULT: PASS" sim.log

// File: src.f
verilog/sonic_vc_pkg.sv
verilog/rx_beat_if.sv
verilog/tx_vc_arbiter.sv
verilog/rx_channel_classifier.sv
verilog/rx_vc_demux.sv
verilog/sonic_vc_bridge.sv
tb/sonic_vc_bridge_tb.sv

// File: tb/sonic_vc_bridge_tb.sv
/*
 * Testbench for the virtual-channel bridge. Random transmit packets on
 * both ports and random receive packets are checked against queue models
 * built from the header steering and half-word packing rules.
 */

`timescale 1ns/1ns
`default_nettype none

module sonic_vc_bridge_tb;

   localparam int max_beats = (2 * 30 + 2 * 20 + 60) * 4;   // longest possible stimulus
   localparam int cycle_limit = 4 * max_beats + 200;

   logic pld_clk = 1'b0;
   logic rst_n = 1'b0;
   logic rst_drive = 1'b0;
   logic [74:0] tx_lo [2];
   logic [74:0] tx_hi [2];
   logic [1:0] tx_valid;
   wire [1:0] tx_rdy;
   wire [127:0] tx_out_data;
   wire tx_out_sop, tx_out_eop, tx_out_empty, tx_out_err, tx_out_chan, tx_out_valid;
   logic tx_out_ready;
   logic [127:0] rx_in_data;
   logic rx_in_sop, rx_in_eop, rx_in_empty, rx_in_valid;
   logic [7:0] rx_in_bardec;
   logic [15:0] rx_in_be;
   wire rx_in_ready;
   wire [81:0] rx_w0 [2];
   wire [81:0] rx_w1 [2];
   wire [1:0] rx_ov;
   logic [1:0] rx_or;

   // model state
   logic [131:0] tx_q [2][$];       // err, empty, eop, sop, data
   logic [163:0] rx_q [2][$];       // word1, word0
   logic [131:0] tx_exp [2];
   logic [1:0] tx_held, tx_took;
   int tx_beats [2];
   int tx_pkts [2];
   logic tx_on, tx_alt, tx_in_pkt, tx_last, tx_last_ok;
   logic rx_on, rx_held, rx_took, model_chan;
   int rx_beats, rx_pkts;
   int errors = 0;
   int tests_pass = 0;
   int tests_fail = 0;
   int cycle_cnt = 0;
   logic [7:0] steer [8] = '{8'h40, 8'h60, 8'h45, 8'h42, 8'h4A, 8'h4B, 8'h06, 8'h0B};

   sonic_vc_bridge dut_i (
      .pld_clk (pld_clk), .rst_n (rst_n),
      .tx_in0_lo (tx_lo[0]), .tx_in0_hi (tx_hi[0]), .tx_in0_valid (tx_valid[0]),
      .tx_in0_ready (tx_rdy[0]),
      .tx_in1_lo (tx_lo[1]), .tx_in1_hi (tx_hi[1]), .tx_in1_valid (tx_valid[1]),
      .tx_in1_ready (tx_rdy[1]),
      .tx_out_data (tx_out_data), .tx_out_sop (tx_out_sop), .tx_out_eop (tx_out_eop),
      .tx_out_empty (tx_out_empty), .tx_out_err (tx_out_err), .tx_out_chan (tx_out_chan),
      .tx_out_valid (tx_out_valid), .tx_out_ready (tx_out_ready),
      .rx_in_data (rx_in_data), .rx_in_sop (rx_in_sop), .rx_in_eop (rx_in_eop),
      .rx_in_empty (rx_in_empty), .rx_in_bardec (rx_in_bardec), .rx_in_be (rx_in_be),
      .rx_in_valid (rx_in_valid), .rx_in_ready (rx_in_ready),
      .rx_out0_word0 (rx_w0[0]), .rx_out0_word1 (rx_w1[0]), .rx_out0_valid (rx_ov[0]),
      .rx_out0_ready (rx_or[0]),
      .rx_out1_word0 (rx_w0[1]), .rx_out1_word1 (rx_w1[1]), .rx_out1_valid (rx_ov[1]),
      .rx_out1_ready (rx_or[1])
   );

   always #10 pld_clk = ~pld_clk;

   always @(posedge pld_clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   initial begin
      wait (cycle_cnt >= cycle_limit);
      $display("timeout after %0d cycles, traffic did not drain", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   function automatic logic [127:0] rnd128();
      return {$urandom, $urandom, $urandom, $urandom};
   endfunction

   function automatic logic steer_hit(input logic [127:0] d);
      logic hit;
      hit = 1'b0;
      for (int i = 0; i < 8; i++) begin
         if (d[31:24] == steer[i]) hit = 1'b1;
      end
      return hit;
   endfunction

   task automatic check(input string name, input logic [163:0] got, input logic [163:0] exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic drive_tx();
      logic [127:0] r;
      logic first;
      for (int p = 0; p < 2; p++) begin
         if (tx_took[p]) tx_held[p] = 1'b0;
         if (tx_on && !tx_held[p] && (tx_beats[p] > 0 || tx_pkts[p] > 0) &&
             (tx_alt || ($urandom % 4) != 0)) begin
            first = (tx_beats[p] == 0);
            if (first) begin
               tx_beats[p] = 1 + int'($urandom % 4);
               tx_pkts[p]--;
            end
            r = rnd128();
            tx_lo[p] = r[74:0];
            tx_lo[p][73] = first;
            r = rnd128();
            tx_hi[p] = r[74:0];
            tx_hi[p][72] = (tx_beats[p] == 1);   // eop flag of the hi view
            tx_beats[p]--;
            tx_held[p] = 1'b1;
            tx_exp[p] = {tx_lo[p][74], tx_lo[p][72], tx_hi[p][72], tx_lo[p][73],
                         tx_hi[p][63:0], tx_lo[p][63:0]};
         end
      end
      tx_valid = tx_held;
      tx_out_ready = tx_alt ? 1'b1 : (tx_on && ($urandom % 4) != 0);
   endtask

   task automatic drive_rx();
      logic [127:0] r;
      logic [31:0] s;
      if (rx_took) rx_held = 1'b0;
      if (rx_on && !rx_held && (rx_beats > 0 || rx_pkts > 0) && ($urandom % 4) != 0) begin
         r = rnd128();
         rx_in_sop = (rx_beats == 0);
         if (rx_in_sop) begin
            rx_beats = 1 + int'($urandom % 4);
            rx_pkts--;
            if (($urandom % 2) != 0) r[31:24] = steer[$urandom % 8];
         end
         rx_in_data = r;
         rx_in_eop = (rx_beats == 1);
         s = $urandom;
         rx_in_empty = s[0];
         rx_in_bardec = s[15:8];
         rx_in_be = s[31:16];
         rx_beats--;
         rx_held = 1'b1;
      end
      rx_in_valid = rx_held;
      s = $urandom;
      rx_or = rx_on ? {s[1:0] != 2'b00, s[3:2] != 2'b00} : 2'b00;
   endtask

   task automatic sample_tx();
      logic [131:0] e;
      logic c;
      for (int p = 0; p < 2; p++) begin
         tx_took[p] = tx_valid[p] && tx_rdy[p];
         if (tx_took[p]) tx_q[p].push_back(tx_exp[p]);
      end
      if (tx_out_valid && tx_out_ready) begin
         c = tx_out_chan;
         if (tx_q[c].size() == 0) begin
            errors++;
            $display("transmit beat on channel %0d that no port sent", c);
         end else begin
            e = tx_q[c].pop_front();
            check("tx_out_data", 164'(tx_out_data), 164'(e[127:0]));
            check("tx_out_err,empty,eop,sop",
                  164'({tx_out_err, tx_out_empty, tx_out_eop, tx_out_sop}), 164'(e[131:128]));
         end
         if (tx_out_sop) begin
            if (tx_alt && tx_last_ok && c == tx_last && tx_pkts[0] > 0 && tx_pkts[1] > 0) begin
               errors++;
               $display("two packets in a row on channel %0d while both ports were busy", c);
            end
            tx_in_pkt = 1'b1;
            tx_last = c;
            tx_last_ok = 1'b1;
         end else if (tx_in_pkt && c != tx_last) begin
            errors++;
            $display("transmit channel changed inside a packet");
         end
         if (tx_out_eop) tx_in_pkt = 1'b0;
      end
   endtask

   task automatic sample_rx();
      logic [163:0] e;
      logic [81:0] w0;
      logic [81:0] w1;
      rx_took = rx_in_valid && rx_in_ready;
      if (rx_took) begin
         if (rx_in_sop && steer_hit(rx_in_data)) model_chan = rx_in_data[22];
         w0 = {rx_in_be[7:0], rx_in_sop, rx_in_empty, rx_in_bardec, rx_in_data[63:0]};
         w1 = {rx_in_be[15:8], rx_in_sop, rx_in_eop, rx_in_bardec, rx_in_data[127:64]};
         rx_q[model_chan].push_back({w1, w0});
      end
      for (int p = 0; p < 2; p++) begin
         if (rx_ov[p] && rx_or[p]) begin
            if (rx_q[p].size() == 0) begin
               errors++;
               $display("receive beat on port %0d that the model did not expect", p);
            end else begin
               e = rx_q[p].pop_front();
               check($sformatf("rx_out%0d_word0", p), 164'(rx_w0[p]), 164'(e[81:0]));
               check($sformatf("rx_out%0d_word1", p), 164'(rx_w1[p]), 164'(e[163:82]));
            end
         end
      end
   endtask

   task automatic step();
      @(posedge pld_clk);
      #2;
      rst_n = rst_drive;
      drive_tx();
      drive_rx();
      @(negedge pld_clk);
      sample_tx();
      sample_rx();
   endtask

   function automatic logic all_done();
      return tx_pkts[0] == 0 && tx_pkts[1] == 0 && tx_beats[0] == 0 && tx_beats[1] == 0 &&
             tx_held == 2'b00 && tx_q[0].size() == 0 && tx_q[1].size() == 0 &&
             !tx_out_valid && rx_pkts == 0 && rx_beats == 0 && !rx_held &&
             rx_q[0].size() == 0 && rx_q[1].size() == 0 && rx_ov == 2'b00;
   endfunction

   task automatic finish_test(input string name, input int err0);
      if (errors == err0) begin
         tests_pass++;
         $display("test %s passed", name);
      end else begin
         tests_fail++;
         $display("test %s failed with %0d errors", name, errors - err0);
      end
   endtask

   task automatic run_test(input string name);
      int err0;
      err0 = errors;
      while (!all_done()) step();
      finish_test(name, err0);
   endtask

   initial begin
      int err0;
      void'($urandom(32'he831));
      tx_lo = '{default: '0};
      tx_hi = '{default: '0};
      tx_valid = '0;
      tx_out_ready = 1'b0;
      rx_in_data = '0;
      {rx_in_sop, rx_in_eop, rx_in_empty, rx_in_valid} = '0;
      rx_in_bardec = '0;
      rx_in_be = '0;
      rx_or = '0;
      {tx_held, tx_took} = '0;
      tx_beats = '{0, 0};
      tx_pkts = '{0, 0};
      {tx_on, tx_alt, tx_in_pkt, tx_last, tx_last_ok} = '0;
      {rx_on, rx_held, rx_took, model_chan} = '0;
      rx_beats = 0;
      rx_pkts = 0;

      err0 = errors;
      for (int i = 0; i < 15; i++) begin
         rst_drive = (i >= 10);   // 10 cycles in reset
         step();
         if (i > 0) begin
            check("tx_out_valid", 164'(tx_out_valid), 164'(0));
            check("rx_out valids", 164'(rx_ov), 164'(0));
            check("tx_in readys", 164'(tx_rdy), 164'(0));
         end
      end
      finish_test("reset", err0);

      tx_on = 1'b1;
      tx_pkts = '{30, 30};
      run_test("tx_random");
      tx_alt = 1'b1;
      tx_pkts = '{20, 20};
      run_test("tx_alternate");
      tx_on = 1'b0;
      tx_alt = 1'b0;
      rx_on = 1'b1;
      rx_pkts = 60;
      run_test("rx_random");

      $display("tests passed %0d failed %0d errors %0d", tests_pass, tests_fail, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/rx_beat_if.sv
/*
 * One receive beat after channel classification, with its sideband.
 * The classifier drives the beat, the demultiplexer answers with ready.
 */

`timescale 1ns/1ns
`default_nettype none

interface rx_beat_if;
   import sonic_vc_pkg::*;

   logic [st_data_w-1:0] data;
   logic                 sop;
   logic                 eop;
   logic                 empty;
   logic                 chan;    // target port
   logic [bardec_w-1:0]  bardec;
   logic [be_w-1:0]      be;
   logic                 valid;
   logic                 ready;

   modport cls (output data, sop, eop, empty, chan, bardec, be, valid, input ready);
   modport dmx (input data, sop, eop, empty, chan, bardec, be, valid, output ready);
endinterface

`default_nettype wire

// File: verilog/rx_channel_classifier.sv
/*
 * Receive channel decode. A start-of-packet beat whose fmt/type byte is
 * a steering code selects the port from header bit 22; every other beat
 * uses the channel last chosen. Beats pass through without delay.
 */

`timescale 1ns/1ns
`default_nettype none

module rx_channel_classifier (
   input  logic                               pld_clk,
   input  logic                               rst_n,
   input  logic [sonic_vc_pkg::st_data_w-1:0] rx_in_data,
   input  logic                               rx_in_sop,
   input  logic                               rx_in_eop,
   input  logic                               rx_in_empty,
   input  logic [sonic_vc_pkg::bardec_w-1:0]  rx_in_bardec,
   input  logic [sonic_vc_pkg::be_w-1:0]      rx_in_be,
   input  logic                               rx_in_valid,
   output logic                               rx_in_ready,
   rx_beat_if.cls                             beat
);
   import sonic_vc_pkg::*;

   logic [7:0] fmt_type;
   logic       code_hit;
   logic       chan_hit;
   logic       chan_q;     // held for the rest of the packet

   assign fmt_type = rx_in_data[hdr_fmt_type_lsb +: 8];

   always_comb begin
      code_hit = 1'b0;
      for (int i = 0; i < num_steer; i++) begin
         if (fmt_type == steer_codes[i]) begin
            code_hit = 1'b1;
         end
      end
   end

   assign chan_hit = rx_in_sop && code_hit;

   always_ff @(posedge pld_clk) begin
      if (!rst_n) begin
         chan_q <= 1'b0;
      end else if (rx_in_valid && beat.ready && chan_hit) begin
         chan_q <= rx_in_data[hdr_chan_bit];
      end
   end

   assign beat.data   = rx_in_data;
   assign beat.sop    = rx_in_sop;
   assign beat.eop    = rx_in_eop;
   assign beat.empty  = rx_in_empty;
   assign beat.bardec = rx_in_bardec;
   assign beat.be     = rx_in_be;
   assign beat.valid  = rx_in_valid;
   assign beat.chan   = chan_hit ? rx_in_data[hdr_chan_bit] : chan_q;
   assign rx_in_ready = beat.ready;

endmodule

`default_nettype wire

// File: verilog/rx_vc_demux.sv
/*
 * Receive demultiplexer. Two register stages carry the beat, its channel
 * and its sideband; the last stage presents the beat to one port as two
 * packed 82-bit words. All stages move together, so a stalled port
 * also holds back traffic for the other one.
 */

`timescale 1ns/1ns
`default_nettype none

module rx_vc_demux (
   input  logic                               pld_clk,
   input  logic                               rst_n,
   rx_beat_if.dmx                             beat,
   output logic [sonic_vc_pkg::rx_word_w-1:0] rx_out0_word0,
   output logic [sonic_vc_pkg::rx_word_w-1:0] rx_out0_word1,
   output logic [sonic_vc_pkg::rx_word_w-1:0] rx_out1_word0,
   output logic [sonic_vc_pkg::rx_word_w-1:0] rx_out1_word1,
   output logic                               rx_out0_valid,
   output logic                               rx_out1_valid,
   input  logic                               rx_out0_ready,
   input  logic                               rx_out1_ready
);
   import sonic_vc_pkg::*;

   // index 0 is the first stage, 1 the output stage
   logic [1:0]           valid_q;
   logic [st_data_w-1:0] data_q   [2];
   logic                 sop_q    [2];
   logic                 eop_q    [2];
   logic                 empty_q  [2];
   logic                 chan_q   [2];
   logic [bardec_w-1:0]  bardec_q [2];
   logic [be_w-1:0]      be_q     [2];
   logic [num_ports-1:0] port_ready;
   logic                 advance;
   logic [rx_word_w-1:0] word0;
   logic [rx_word_w-1:0] word1;

   assign port_ready = {rx_out1_ready, rx_out0_ready};
   assign advance    = !valid_q[1] || port_ready[chan_q[1]];
   assign beat.ready = advance;

   always_ff @(posedge pld_clk) begin
      if (!rst_n) begin
         valid_q <= '0;
      end else if (advance) begin
         valid_q <= {valid_q[0], beat.valid};
      end
   end

   always_ff @(posedge pld_clk) begin
      if (advance) begin
         data_q[0]   <= beat.data;
         sop_q[0]    <= beat.sop;
         eop_q[0]    <= beat.eop;
         empty_q[0]  <= beat.empty;
         chan_q[0]   <= beat.chan;
         bardec_q[0] <= beat.bardec;
         be_q[0]     <= beat.be;
         data_q[1]   <= data_q[0];
         sop_q[1]    <= sop_q[0];
         eop_q[1]    <= eop_q[0];
         empty_q[1]  <= empty_q[0];
         chan_q[1]   <= chan_q[0];
         bardec_q[1] <= bardec_q[0];
         be_q[1]     <= be_q[0];
      end
   end

   // low half with empty, high half with eop
   assign word0 = {be_q[1][be_w/2-1:0], sop_q[1], empty_q[1], bardec_q[1],
                   data_q[1][half_data_w-1:0]};
   assign word1 = {be_q[1][be_w-1:be_w/2], sop_q[1], eop_q[1], bardec_q[1],
                   data_q[1][st_data_w-1:half_data_w]};

   assign rx_out0_word0 = word0;
   assign rx_out0_word1 = word1;
   assign rx_out1_word0 = word0;
   assign rx_out1_word1 = word1;
   assign rx_out0_valid = valid_q[1] && !chan_q[1];
   assign rx_out1_valid = valid_q[1] && chan_q[1];

endmodule

`default_nettype wire

// File: verilog/sonic_vc_bridge.sv
/*
 * Top level of the two-port virtual-channel bridge between one PCIe
 * streaming interface and two application ports. Transmit beats from the
 * ports are arbitrated onto one tagged stream; receive beats are steered
 * to a port by their TLP header.
 */

`timescale 1ns/1ns
`default_nettype none

module sonic_vc_bridge (
   input  logic                               pld_clk,
   input  logic                               rst_n,
   input  logic [sonic_vc_pkg::tx_half_w-1:0] tx_in0_lo,
   input  logic [sonic_vc_pkg::tx_half_w-1:0] tx_in0_hi,
   input  logic                               tx_in0_valid,
   output logic                               tx_in0_ready,
   input  logic [sonic_vc_pkg::tx_half_w-1:0] tx_in1_lo,
   input  logic [sonic_vc_pkg::tx_half_w-1:0] tx_in1_hi,
   input  logic                               tx_in1_valid,
   output logic                               tx_in1_ready,
   output logic [sonic_vc_pkg::st_data_w-1:0] tx_out_data,
   output logic                               tx_out_sop,
   output logic                               tx_out_eop,
   output logic                               tx_out_empty,
   output logic                               tx_out_err,
   output logic                               tx_out_chan,
   output logic                               tx_out_valid,
   input  logic                               tx_out_ready,
   input  logic [sonic_vc_pkg::st_data_w-1:0] rx_in_data,
   input  logic                               rx_in_sop,
   input  logic                               rx_in_eop,
   input  logic                               rx_in_empty,
   input  logic [sonic_vc_pkg::bardec_w-1:0]  rx_in_bardec,
   input  logic [sonic_vc_pkg::be_w-1:0]      rx_in_be,
   input  logic                               rx_in_valid,
   output logic                               rx_in_ready,
   output logic [sonic_vc_pkg::rx_word_w-1:0] rx_out0_word0,
   output logic [sonic_vc_pkg::rx_word_w-1:0] rx_out0_word1,
   output logic                               rx_out0_valid,
   input  logic                               rx_out0_ready,
   output logic [sonic_vc_pkg::rx_word_w-1:0] rx_out1_word0,
   output logic [sonic_vc_pkg::rx_word_w-1:0] rx_out1_word1,
   output logic                               rx_out1_valid,
   input  logic                               rx_out1_ready
);

   rx_beat_if beat_if ();   // classifier to demux

   tx_vc_arbiter arb_i (
      .tx_in0_lo (tx_in0_lo),
      .tx_in0_hi (tx_in0_hi),
      .tx_in1_lo (tx_in1_lo),
      .tx_in1_hi (tx_in1_hi),
      .*
   );

   rx_channel_classifier cls_i (
      .beat (beat_if.cls),
      .*
   );

   rx_vc_demux dmx_i (
      .beat (beat_if.dmx),
      .*
   );

endmodule

`default_nettype wire

// File: verilog/sonic_vc_pkg.sv
/*
 * Shared widths, header decode constants and the transmit half-word
 * type for the two-port virtual-channel bridge.
 * Modules import it inside their body; port lists use scoped names.
 */

`default_nettype none

package sonic_vc_pkg;

   // streaming beat
   localparam int st_data_w   = 128;
   localparam int half_data_w = st_data_w / 2;
   localparam int rx_word_w   = 82;             // be byte, sop, flag, bardec, data half
   localparam int bardec_w    = 8;
   localparam int be_w        = 16;
   localparam int num_ports   = 2;

   // transmit half-word layout
   localparam int tx_err_bit  = 74;
   localparam int tx_sop_bit  = tx_err_bit - 1;
   localparam int tx_flag_bit = tx_sop_bit - 1; // empty in lo, eop in hi
   localparam int tx_half_w   = tx_err_bit + 1;

   // TLP header dword 0
   localparam int hdr_fmt_type_lsb = 24;
   localparam int hdr_chan_bit     = 22;

   // fmt/type bytes that carry a channel select
   localparam int num_steer = 8;
   localparam logic [7:0] steer_codes [num_steer] = '{
      8'h40, 8'h60, 8'h45, 8'h42, 8'h4A, 8'h4B, 8'h06, 8'h0B
   };

   // one 75-bit half word, read as the first or the second half of a beat
   typedef union packed {
      struct packed {
         logic                                err;
         logic                                sop;
         logic                                empty;
         logic [tx_flag_bit-half_data_w-1:0] rsvd;
         logic [half_data_w-1:0]              data;
      } lo;
      struct packed {
         logic                                err;
         logic                                sop;
         logic                                eop;
         logic [tx_flag_bit-half_data_w-1:0] rsvd;
         logic [half_data_w-1:0]              data;
      } hi;
   } tx_half_u;

endpackage

`default_nettype wire

// File: verilog/tx_vc_arbiter.sv
/*
 * Transmit side of the bridge. Each port offers a beat as two half words;
 * the winning port's halves are joined into one 128-bit beat and
 * registered onto the output stream with the port index as channel.
 * Arbitration is per packet, round robin, grant held until eop is taken.
 */

`timescale 1ns/1ns
`default_nettype none

module tx_vc_arbiter (
   input  logic                            pld_clk,
   input  logic                            rst_n,
   input  sonic_vc_pkg::tx_half_u          tx_in0_lo,
   input  sonic_vc_pkg::tx_half_u          tx_in0_hi,
   input  sonic_vc_pkg::tx_half_u          tx_in1_lo,
   input  sonic_vc_pkg::tx_half_u          tx_in1_hi,
   input  logic                            tx_in0_valid,
   input  logic                            tx_in1_valid,
   output logic                            tx_in0_ready,
   output logic                            tx_in1_ready,
   output logic [sonic_vc_pkg::st_data_w-1:0] tx_out_data,
   output logic                            tx_out_sop,
   output logic                            tx_out_eop,
   output logic                            tx_out_empty,
   output logic                            tx_out_err,
   output logic                            tx_out_chan,
   output logic                            tx_out_valid,
   input  logic                            tx_out_ready
);
   import sonic_vc_pkg::*;

   tx_half_u             in_lo [num_ports];
   tx_half_u             in_hi [num_ports];
   tx_half_u             sel_lo;
   tx_half_u             sel_hi;
   logic [num_ports-1:0] in_valid;
   logic                 gnt_act_q;   // a port holds the grant
   logic                 gnt_idx_q;
   logic                 pref_q;      // next port to favour
   logic                 pref_n;
   logic                 out_free;
   logic                 take;
   logic                 eop_taken;

   assign in_lo[0] = tx_in0_lo;
   assign in_lo[1] = tx_in1_lo;
   assign in_hi[0] = tx_in0_hi;
   assign in_hi[1] = tx_in1_hi;
   assign in_valid = {tx_in1_valid, tx_in0_valid};

   assign sel_lo = in_lo[gnt_idx_q];
   assign sel_hi = in_hi[gnt_idx_q];

   assign out_free     = !tx_out_valid || tx_out_ready;
   assign tx_in0_ready = gnt_act_q && !gnt_idx_q && out_free;
   assign tx_in1_ready = gnt_act_q && gnt_idx_q && out_free;
   assign take         = gnt_act_q && out_free && in_valid[gnt_idx_q];
   assign eop_taken    = take && sel_hi.hi.eop;
   assign pref_n       = eop_taken ? ~gnt_idx_q : pref_q;

   always_ff @(posedge pld_clk) begin
      if (!rst_n) begin
         gnt_act_q <= 1'b0;
         gnt_idx_q <= 1'b0;
         pref_q    <= 1'b0;
      end else begin
         if (eop_taken) begin
            pref_q <= ~gnt_idx_q;
         end
         if (!gnt_act_q || eop_taken) begin
            if (in_valid[pref_n]) begin
               gnt_act_q <= 1'b1;
               gnt_idx_q <= pref_n;
            end else if (in_valid[~pref_n] && !eop_taken) begin
               gnt_act_q <= 1'b1;
               gnt_idx_q <= ~pref_n;
            end else begin
               gnt_act_q <= 1'b0;   // idle, rearbitrate next cycle
            end
         end
      end
   end

   always_ff @(posedge pld_clk) begin
      if (!rst_n) begin
         tx_out_valid <= 1'b0;
      end else if (out_free) begin
         tx_out_valid <= take;
      end
   end

   always_ff @(posedge pld_clk) begin
      if (take) begin
         tx_out_data  <= {sel_hi.hi.data, sel_lo.lo.data};
         tx_out_sop   <= sel_lo.lo.sop;
         tx_out_eop   <= sel_hi.hi.eop;
         tx_out_empty <= sel_lo.lo.empty;
         tx_out_err   <= sel_lo.lo.err;
         tx_out_chan  <= gnt_idx_q;
      end
   end

endmodule

`default_nettype wire
